// ==== logic/brisc_pkg.sv ====
`default_nettype none

package brisc_pkg;

  // Data path widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned BYTE_WIDTH = 8;
  localparam int unsigned ADDRESS_WIDTH = 16;
  localparam int unsigned CACHE_LINE_WIDTH = 128;

  // Default geometry
  localparam int unsigned NUM_CACHE_LINES = 16;
  localparam int unsigned STB_DEPTH = 4;

  localparam int unsigned WORDS_PER_LINE = CACHE_LINE_WIDTH / WORD_WIDTH;
  localparam int unsigned BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;
  localparam int unsigned BYTES_PER_LINE = CACHE_LINE_WIDTH / BYTE_WIDTH;
  localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(BYTES_PER_WORD);
  localparam int unsigned WORD_OFFSET_WIDTH = $clog2(WORDS_PER_LINE);
  localparam int unsigned INDEX_WIDTH = $clog2(NUM_CACHE_LINES);
  localparam int unsigned TAG_WIDTH =
      ADDRESS_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFFSET_WIDTH;

  typedef enum logic {
    B = 1'b0,
    W = 1'b1
  } data_size_e;

  // Byte address split for a direct-mapped lookup
  typedef struct packed {
    logic [TAG_WIDTH-1:0]         tag;
    logic [INDEX_WIDTH-1:0]       index;
    logic [WORD_OFFSET_WIDTH-1:0] word_offset;
    logic [BYTE_OFFSET_WIDTH-1:0] byte_offset;
  } addr_fields_t;

  // One line, read either by word or by byte
  typedef union packed {
    logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] words;
    logic [BYTES_PER_LINE-1:0][BYTE_WIDTH-1:0] bytes;
  } cache_line_u;

  typedef struct packed {
    logic [ADDRESS_WIDTH-1:0] line_addr;
    cache_line_u              data;
    logic                     write;
  } mem_req_t;

  // Byte stores keep their byte in data[7:0]
  typedef struct packed {
    addr_fields_t     addr;
    logic [XLEN-1:0]  data;
    data_size_e       size;
    logic             valid;
  } stb_entry_t;

endpackage

`default_nettype wire

// ==== logic/dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
  parameter int unsigned NUM_LINES = brisc_pkg::NUM_CACHE_LINES
) (
  input  logic                                clk,
  input  logic                                reset,
  input  brisc_pkg::addr_fields_t             lookup_addr,
  output brisc_pkg::cache_line_u              lookup_line,
  output logic                                lookup_hit,
  input  brisc_pkg::addr_fields_t             drain_addr,
  output logic                                drain_hit,
  input  logic                                drain_write,
  input  logic [brisc_pkg::XLEN-1:0]          drain_data,
  input  brisc_pkg::data_size_e               drain_size,
  input  logic                                fill,
  input  brisc_pkg::addr_fields_t             fill_addr,
  input  brisc_pkg::cache_line_u              fill_data,
  input  logic                                victim_sel,
  output logic                                victim_dirty,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] victim_addr,
  output brisc_pkg::cache_line_u              victim_line
);

  logic [brisc_pkg::TAG_WIDTH-1:0]   tag_q [NUM_LINES];
  logic [NUM_LINES-1:0]              valid_q;
  logic [NUM_LINES-1:0]              dirty_q;
  brisc_pkg::cache_line_u            data_q [NUM_LINES];

  logic [brisc_pkg::INDEX_WIDTH-1:0] victim_idx;
  brisc_pkg::addr_fields_t           victim_fields;
  brisc_pkg::cache_line_u            merge_line;

  // Pipeline load lookup
  assign lookup_line = data_q[lookup_addr.index];
  assign lookup_hit = valid_q[lookup_addr.index] &&
                      (tag_q[lookup_addr.index] == lookup_addr.tag);

  // Is the line of the oldest store resident
  assign drain_hit = valid_q[drain_addr.index] &&
                     (tag_q[drain_addr.index] == drain_addr.tag);

  // Victim sits at the index of the address being resolved
  assign victim_idx = victim_sel ? drain_addr.index : lookup_addr.index;
  assign victim_dirty = valid_q[victim_idx] & dirty_q[victim_idx];
  assign victim_line = data_q[victim_idx];

  always_comb begin
    victim_fields = '0;
    victim_fields.tag = tag_q[victim_idx];
    victim_fields.index = victim_idx;
  end

  assign victim_addr = victim_fields;

  // Store data merged into the resident line
  always_comb begin
    merge_line = data_q[drain_addr.index];
    if (drain_size == brisc_pkg::W) begin
      merge_line.words[drain_addr.word_offset] = drain_data;
    end else begin
      merge_line.bytes[{drain_addr.word_offset, drain_addr.byte_offset}] =
          drain_data[brisc_pkg::BYTE_WIDTH-1:0];
    end
  end

  // Line state
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      valid_q[fill_addr.index] <= 1'b1;
      dirty_q[fill_addr.index] <= 1'b0;
    end else if (drain_write) begin
      dirty_q[drain_addr.index] <= 1'b1;
    end
  end

  // Tags and line data
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[fill_addr.index] <= fill_addr.tag;
      data_q[fill_addr.index] <= fill_data;
    end else if (drain_write) begin
      data_q[drain_addr.index] <= merge_line;
    end
  end

  // Controller only drains while no transaction is outstanding
  assert property (@(posedge clk) disable iff (reset) !(fill && drain_write))
    else $error("dcache_array: fill and store drain in the same cycle");

endmodule

`default_nettype wire

// ==== logic/store_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer #(
  parameter int unsigned STB_ENTRIES = brisc_pkg::STB_DEPTH
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push,
  input  brisc_pkg::stb_entry_t      push_entry,
  output logic                       full,
  input  brisc_pkg::addr_fields_t    load_addr,
  input  brisc_pkg::data_size_e      load_size,
  output logic                       fwd_valid,
  output logic [brisc_pkg::XLEN-1:0] fwd_word,
  output logic                       fwd_conflict,
  output brisc_pkg::stb_entry_t      head,
  input  logic                       pop
);

  localparam int unsigned PTR_W = (STB_ENTRIES > 1) ? $clog2(STB_ENTRIES) : 1;
  localparam int unsigned CNT_W = $clog2(STB_ENTRIES + 1);

  brisc_pkg::stb_entry_t entries_q [STB_ENTRIES];
  logic [STB_ENTRIES-1:0] slot_valid_q;
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;

  brisc_pkg::stb_entry_t  match_entry;
  logic                   match_found;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(STB_ENTRIES - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count_q == CNT_W'(STB_ENTRIES));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      slot_valid_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
        slot_valid_q[wr_ptr_q] <= push_entry.valid;
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
        slot_valid_q[rd_ptr_q] <= 1'b0;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries_q[wr_ptr_q] <= push_entry;
    end
  end

  // Oldest entry offered to the cache
  always_comb begin
    head = entries_q[rd_ptr_q];
    head.valid = slot_valid_q[rd_ptr_q];
  end

  // Walk oldest to newest so the last match wins
  always_comb begin
    int unsigned slot;
    match_found = 1'b0;
    match_entry = '0;
    for (int unsigned i = 0; i < STB_ENTRIES; i++) begin
      slot = (int'(rd_ptr_q) + i) % STB_ENTRIES;
      if (slot_valid_q[slot] &&
          entries_q[slot].addr.tag == load_addr.tag &&
          entries_q[slot].addr.index == load_addr.index &&
          entries_q[slot].addr.word_offset == load_addr.word_offset) begin
        match_found = 1'b1;
        match_entry = entries_q[slot];
      end
    end
  end

  always_comb begin
    fwd_valid = 1'b0;
    fwd_conflict = 1'b0;
    if (match_found) begin
      if (match_entry.size == brisc_pkg::W) begin
        fwd_valid = 1'b1;
      end else if (load_size == brisc_pkg::B &&
                   match_entry.addr.byte_offset == load_addr.byte_offset) begin
        fwd_valid = 1'b1;
      end else begin
        // partial overlap, wait for the drain
        fwd_conflict = 1'b1;
      end
    end
  end

  // Byte copied to every lane so the aligner can pick it by offset
  assign fwd_word = (match_entry.size == brisc_pkg::W) ? match_entry.data :
                    {brisc_pkg::BYTES_PER_WORD{match_entry.data[brisc_pkg::BYTE_WIDTH-1:0]}};

  assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("store_buffer: push while full");

  assert property (@(posedge clk) disable iff (reset) pop |-> head.valid)
    else $error("store_buffer: pop while empty");

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  brisc_pkg::cache_line_u     line,
  input  logic [brisc_pkg::XLEN-1:0] fwd_word,
  input  logic                       use_fwd,
  input  brisc_pkg::addr_fields_t    addr,
  input  brisc_pkg::data_size_e      size,
  output logic [brisc_pkg::XLEN-1:0] read_data
);

  logic [brisc_pkg::BYTES_PER_WORD-1:0][brisc_pkg::BYTE_WIDTH-1:0] fwd_bytes;
  logic [brisc_pkg::WORD_WIDTH-1:0] sel_word;
  logic [brisc_pkg::BYTE_WIDTH-1:0] sel_byte;

  // Byte lanes of the forwarded word
  assign fwd_bytes = fwd_word;

  always_comb begin
    if (use_fwd) begin
      sel_word = fwd_word;
      sel_byte = fwd_bytes[addr.byte_offset];
    end else begin
      sel_word = line.words[addr.word_offset];
      sel_byte = line.bytes[{addr.word_offset, addr.byte_offset}];
    end
  end

  // Zero-extend byte loads
  assign read_data = (size == brisc_pkg::W) ? sel_word :
                     {{(brisc_pkg::XLEN - brisc_pkg::BYTE_WIDTH){1'b0}}, sel_byte};

endmodule

`default_nettype wire

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
  parameter int unsigned NUM_LINES = brisc_pkg::NUM_CACHE_LINES
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load_req,
  input  brisc_pkg::addr_fields_t             load_addr,
  input  logic                                lookup_hit,
  input  logic                                fwd_valid,
  input  logic                                fwd_conflict,
  input  brisc_pkg::stb_entry_t               stb_head,
  input  logic                                drain_hit,
  input  logic                                victim_dirty,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] victim_addr,
  input  brisc_pkg::cache_line_u              victim_line,
  output logic                                victim_sel,
  output logic                                drain_ack,
  input  logic                                arbiter_grant,
  output logic                                arbiter_req,
  output brisc_pkg::mem_req_t                 mem_req,
  input  logic                                mem_resp,
  output logic                                miss
);

  typedef enum logic [1:0] {
    IDLE,
    WB_REQ,
    RD_REQ,
    WAIT_RESP
  } state_e;

  state_e                              state_q;
  logic                                sel_q;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] target_q;
  brisc_pkg::addr_fields_t             target_fields;
  logic                                load_fill;
  logic                                drain_fill;
  logic                                start;

  // Cache miss combined with the store buffer result
  assign miss = load_req & (fwd_conflict | ~(lookup_hit | fwd_valid));

  assign load_fill = load_req & ~lookup_hit & ~fwd_valid;
  assign drain_fill = stb_head.valid & ~drain_hit;
  assign start = (state_q == IDLE) & (load_fill | drain_fill);

  // Load misses win over drain fills
  assign victim_sel = (state_q == IDLE) ? ~load_fill : sel_q;
  assign drain_ack = (state_q == IDLE) & stb_head.valid & drain_hit & ~load_fill;
  assign arbiter_req = (state_q == WB_REQ) | (state_q == RD_REQ);

  always_comb begin
    target_fields = victim_sel ? stb_head.addr : load_addr;
    target_fields.word_offset = '0;
    target_fields.byte_offset = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      sel_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q <= victim_dirty ? WB_REQ : RD_REQ;
            sel_q <= victim_sel;
          end
        end
        WB_REQ:    if (arbiter_grant) state_q <= RD_REQ;
        RD_REQ:    if (arbiter_grant) state_q <= WAIT_RESP;
        WAIT_RESP: if (mem_resp) state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  // Write-back goes out first, then the read of the missing line
  always_ff @(posedge clk) begin
    if (start) begin
      target_q <= target_fields;
      if (victim_dirty) begin
        mem_req.line_addr <= victim_addr;
        mem_req.data <= victim_line;
        mem_req.write <= 1'b1;
      end else begin
        mem_req.line_addr <= target_fields;
        mem_req.data <= '0;
        mem_req.write <= 1'b0;
      end
    end else if (state_q == WB_REQ && arbiter_grant) begin
      mem_req.line_addr <= target_q;
      mem_req.data <= '0;
      mem_req.write <= 1'b0;
    end
  end

  initial begin
    assert (NUM_LINES == (1 << brisc_pkg::INDEX_WIDTH))
      else $error("dcache_ctrl: NUM_LINES does not match the address index field");
  end

  assert property (@(posedge clk) disable iff (reset)
                   (arbiter_req && !arbiter_grant) |=> $stable(mem_req))
    else $error("dcache_ctrl: request changed before grant");

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int unsigned NUM_LINES   = brisc_pkg::NUM_CACHE_LINES,
  parameter int unsigned STB_ENTRIES = brisc_pkg::STB_DEPTH
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   enable,
  input  logic                                   is_load,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0]    addr,
  input  brisc_pkg::data_size_e                  data_size,
  input  logic [brisc_pkg::XLEN-1:0]             store_data,
  output logic                                   miss,
  output logic                                   stall,
  output logic [brisc_pkg::XLEN-1:0]             read_data,
  input  logic                                   arbiter_grant,
  output logic                                   arbiter_req,
  output brisc_pkg::mem_req_t                    mem_req,
  input  logic                                   mem_resp,
  input  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_resp_data,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0]    mem_resp_addr
);

  brisc_pkg::addr_fields_t             req_fields;
  brisc_pkg::addr_fields_t             fill_fields;
  brisc_pkg::cache_line_u              fill_line;
  brisc_pkg::cache_line_u              lookup_line;
  brisc_pkg::cache_line_u              victim_line;
  brisc_pkg::stb_entry_t               push_entry;
  brisc_pkg::stb_entry_t               stb_head;
  logic [brisc_pkg::XLEN-1:0]          fwd_word;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] victim_addr;
  logic                                load_req;
  logic                                stb_push;
  logic                                stb_full;
  logic                                fwd_valid;
  logic                                fwd_conflict;
  logic                                lookup_hit;
  logic                                drain_hit;
  logic                                drain_ack;
  logic                                victim_sel;
  logic                                victim_dirty;

  assign req_fields = addr;
  assign fill_fields = mem_resp_addr;
  assign fill_line = mem_resp_data;

  assign load_req = enable & is_load;
  assign stb_push = enable & ~is_load & ~stb_full;
  assign stall = stb_full;

  always_comb begin
    push_entry.addr = req_fields;
    push_entry.data = store_data;
    push_entry.size = data_size;
    push_entry.valid = 1'b1;
  end

  dcache_array #(
    .NUM_LINES(NUM_LINES)
  ) u_array (
    .clk(clk),
    .reset(reset),
    .lookup_addr(req_fields),
    .lookup_line(lookup_line),
    .lookup_hit(lookup_hit),
    .drain_addr(stb_head.addr),
    .drain_hit(drain_hit),
    .drain_write(drain_ack),
    .drain_data(stb_head.data),
    .drain_size(stb_head.size),
    .fill(mem_resp),
    .fill_addr(fill_fields),
    .fill_data(fill_line),
    .victim_sel(victim_sel),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr),
    .victim_line(victim_line)
  );

  store_buffer #(
    .STB_ENTRIES(STB_ENTRIES)
  ) u_stb (
    .clk(clk),
    .reset(reset),
    .push(stb_push),
    .push_entry(push_entry),
    .full(stb_full),
    .load_addr(req_fields),
    .load_size(data_size),
    .fwd_valid(fwd_valid),
    .fwd_word(fwd_word),
    .fwd_conflict(fwd_conflict),
    .head(stb_head),
    .pop(drain_ack)
  );

  load_align u_align (
    .line(lookup_line),
    .fwd_word(fwd_word),
    .use_fwd(fwd_valid),
    .addr(req_fields),
    .size(data_size),
    .read_data(read_data)
  );

  dcache_ctrl #(
    .NUM_LINES(NUM_LINES)
  ) u_ctrl (
    .clk(clk),
    .reset(reset),
    .load_req(load_req),
    .load_addr(req_fields),
    .lookup_hit(lookup_hit),
    .fwd_valid(fwd_valid),
    .fwd_conflict(fwd_conflict),
    .stb_head(stb_head),
    .drain_hit(drain_hit),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr),
    .victim_line(victim_line),
    .victim_sel(victim_sel),
    .drain_ack(drain_ack),
    .arbiter_grant(arbiter_grant),
    .arbiter_req(arbiter_req),
    .mem_req(mem_req),
    .mem_resp(mem_resp),
    .miss(miss)
  );

endmodule

`default_nettype wire

// ==== dv/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
  parameter int unsigned RESP_DELAY = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [1:0]                             grant_wait,
  input  logic                                   arbiter_req,
  input  brisc_pkg::mem_req_t                    mem_req,
  output logic                                   arbiter_grant,
  output logic                                   mem_resp,
  output logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_resp_data,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0]    mem_resp_addr,
  output int unsigned                            read_count,
  output int unsigned                            write_count
);

  localparam int unsigned MEM_WORDS = 1 << (brisc_pkg::ADDRESS_WIDTH - 2);

  logic [31:0]                         words [MEM_WORDS];
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] pending_addr;
  int unsigned                         wait_count;
  int unsigned                         resp_count;

  // Pattern derived from the full word address
  function automatic logic [31:0] initial_word(input int unsigned widx);
    return (32'(widx) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  initial begin
    arbiter_grant = 1'b0;
    mem_resp = 1'b0;
    mem_resp_data = '0;
    mem_resp_addr = '0;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      words[i] = initial_word(i);
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      arbiter_grant <= 1'b0;
      mem_resp <= 1'b0;
      mem_resp_data <= '0;
      mem_resp_addr <= '0;
      pending_addr <= '0;
      wait_count <= 0;
      resp_count <= 0;
      read_count <= 0;
      write_count <= 0;
    end else begin
      arbiter_grant <= 1'b0;
      mem_resp <= 1'b0;
      if (arbiter_grant) begin
        // mem_req still holds the accepted request this cycle
        wait_count <= 0;
        if (mem_req.write) begin
          for (int i = 0; i < 4; i++) begin
            words[{mem_req.line_addr[15:4], 2'(i)}] <= mem_req.data.words[i];
          end
          write_count <= write_count + 1;
        end else begin
          pending_addr <= mem_req.line_addr;
          resp_count <= RESP_DELAY - 1;
          read_count <= read_count + 1;
        end
      end else if (arbiter_req && resp_count == 0) begin
        if (wait_count + 1 >= 32'(grant_wait)) begin
          arbiter_grant <= 1'b1;
        end else begin
          wait_count <= wait_count + 1;
        end
      end
      if (resp_count != 0) begin
        resp_count <= resp_count - 1;
        if (resp_count == 1) begin
          mem_resp <= 1'b1;
          mem_resp_addr <= pending_addr;
          for (int i = 0; i < 4; i++) begin
            mem_resp_data[32*i +: 32] <= words[{pending_addr[15:4], 2'(i)}];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int unsigned NUM_LINES = 16;
  localparam int unsigned STB_ENTRIES = 4;
  localparam int unsigned CLK_HALF = 2;
  localparam int unsigned RANDOM_OPS = 300;
  localparam int unsigned DIRECTED_ACCESSES = 60;
  localparam longint WATCHDOG_NS = (DIRECTED_ACCESSES + RANDOM_OPS) * 200 * 2 * CLK_HALF;

  logic                                   clk = 1'b0;
  logic                                   reset;
  logic                                   enable;
  logic                                   is_load;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0]    addr;
  brisc_pkg::data_size_e                  data_size;
  logic [brisc_pkg::XLEN-1:0]             store_data;
  logic                                   miss;
  logic                                   stall;
  logic [brisc_pkg::XLEN-1:0]             read_data;
  logic                                   arbiter_grant;
  logic                                   arbiter_req;
  brisc_pkg::mem_req_t                    mem_req;
  logic                                   mem_resp;
  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_resp_data;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0]    mem_resp_addr;
  logic [1:0]                             grant_wait;
  int unsigned                            read_count;
  int unsigned                            write_count;

  logic [31:0]         ref_mem [1 << 14];
  brisc_pkg::mem_req_t grant_log [$];
  logic [31:0]         stim_lfsr = 32'he8a678b6;
  logic [31:0]         grant_lfsr = 32'he8a678b6;
  bit                  stall_seen;
  int                  checks = 0;
  int                  errors = 0;

  always #(CLK_HALF) clk = ~clk;

  dcache_top #(
    .NUM_LINES(NUM_LINES),
    .STB_ENTRIES(STB_ENTRIES)
  ) UUT (
    .clk(clk), .reset(reset), .enable(enable), .is_load(is_load), .addr(addr),
    .data_size(data_size), .store_data(store_data), .miss(miss), .stall(stall),
    .read_data(read_data), .arbiter_grant(arbiter_grant), .arbiter_req(arbiter_req),
    .mem_req(mem_req), .mem_resp(mem_resp), .mem_resp_data(mem_resp_data),
    .mem_resp_addr(mem_resp_addr)
  );

  mem_model u_mem (
    .clk(clk), .reset(reset), .grant_wait(grant_wait), .arbiter_req(arbiter_req),
    .mem_req(mem_req), .arbiter_grant(arbiter_grant), .mem_resp(mem_resp),
    .mem_resp_data(mem_resp_data), .mem_resp_addr(mem_resp_addr),
    .read_count(read_count), .write_count(write_count)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[30:0], state[0]};
    end
  endtask

  // Next grant latency of 1 to 3 cycles
  always @(posedge clk) begin : grant_delay_draw
    logic [31:0] bits;
    if (reset || arbiter_grant) begin
      draw_bits(grant_lfsr, 2, bits);
      grant_wait <= 2'(bits % 3) + 2'd1;
    end
  end

  // Accepted arbiter requests in order
  always @(posedge clk) begin
    if (!reset && arbiter_grant) begin
      grant_log.push_back(mem_req);
    end
  end

  function automatic logic [31:0] initial_word(input int unsigned widx);
    return (32'(widx) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] expected_load(input logic [15:0] a,
                                                input brisc_pkg::data_size_e sz);
    logic [31:0] w;
    w = ref_mem[a[15:2]];
    if (sz == brisc_pkg::W) begin
      return w;
    end
    return {24'h0, w[8*a[1:0] +: 8]};
  endfunction

  function automatic logic [127:0] expected_line(input logic [15:0] line_addr);
    return {ref_mem[{line_addr[15:4], 2'd3}], ref_mem[{line_addr[15:4], 2'd2}],
            ref_mem[{line_addr[15:4], 2'd1}], ref_mem[{line_addr[15:4], 2'd0}]};
  endfunction

  task automatic compare_values(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Inputs held while miss is high
  task automatic issue_load(input logic [15:0] a, input brisc_pkg::data_size_e sz,
                            output logic [31:0] data, output bit saw_miss);
    bit done;
    done = 1'b0;
    saw_miss = 1'b0;
    @(posedge clk);
    enable <= 1'b1;
    is_load <= 1'b1;
    addr <= a;
    data_size <= sz;
    while (!done) begin
      @(negedge clk);
      if (miss) begin
        saw_miss = 1'b1;
        @(posedge clk);
      end else begin
        data = read_data;
        done = 1'b1;
      end
    end
  endtask

  task automatic issue_store(input logic [15:0] a, input brisc_pkg::data_size_e sz,
                             input logic [31:0] d);
    bit done;
    done = 1'b0;
    @(posedge clk);
    enable <= 1'b1;
    is_load <= 1'b0;
    addr <= a;
    data_size <= sz;
    store_data <= d;
    while (!done) begin
      @(negedge clk);
      if (stall) begin
        stall_seen = 1'b1;
        @(posedge clk);
      end else begin
        done = 1'b1;
      end
    end
    if (sz == brisc_pkg::W) begin
      ref_mem[a[15:2]] = d;
    end else begin
      ref_mem[a[15:2]][8*a[1:0] +: 8] = d[7:0];
    end
  endtask

  task automatic load_and_compare(input string name, input logic [15:0] a,
                                  input brisc_pkg::data_size_e sz);
    logic [31:0] data;
    bit saw_miss;
    issue_load(a, sz, data, saw_miss);
    compare_values(name, expected_load(a, sz), data);
  endtask

  task automatic bus_idle(input int cycles);
    @(posedge clk);
    enable <= 1'b0;
    repeat (cycles - 1) @(posedge clk);
  endtask

  task automatic test_cold_miss;
    logic [31:0] data;
    bit saw_miss;
    issue_load(16'h0104, brisc_pkg::W, data, saw_miss);
    compare_values("cold_miss_raised", 1, saw_miss);
    compare_values("cold_data", expected_load(16'h0104, brisc_pkg::W), data);
    compare_values("cold_read_count", 1, read_count);
    compare_values("cold_request_count", 1, grant_log.size());
    compare_values("cold_request_addr", 16'h0100, grant_log[0].line_addr);
    compare_values("cold_request_read", 0, grant_log[0].write);
    issue_load(16'h0108, brisc_pkg::W, data, saw_miss);
    compare_values("warm_no_miss", 0, saw_miss);
    compare_values("warm_data", expected_load(16'h0108, brisc_pkg::W), data);
    compare_values("warm_request_count", 1, grant_log.size());
    compare_values("warm_arbiter_req_low", 0, arbiter_req);
  endtask

  task automatic test_load_sizes;
    for (int i = 0; i < 16; i++) begin
      load_and_compare("byte_offset_load", 16'h0100 + 16'(i), brisc_pkg::B);
    end
    for (int i = 0; i < 4; i++) begin
      load_and_compare("word_offset_load", 16'h0100 + 16'(4 * i), brisc_pkg::W);
    end
  endtask

  task automatic test_forwarding;
    logic [31:0] data;
    bit saw_miss;
    issue_store(16'h0108, brisc_pkg::W, 32'hcafe_f00d);
    issue_load(16'h0108, brisc_pkg::W, data, saw_miss);
    compare_values("fwd_word", expected_load(16'h0108, brisc_pkg::W), data);
    compare_values("fwd_word_no_miss", 0, saw_miss);
    issue_load(16'h010a, brisc_pkg::B, data, saw_miss);
    compare_values("fwd_byte", expected_load(16'h010a, brisc_pkg::B), data);
    issue_store(16'h010d, brisc_pkg::B, 32'h0000_005c);
    issue_load(16'h010c, brisc_pkg::W, data, saw_miss);
    compare_values("byte_merge", expected_load(16'h010c, brisc_pkg::W), data);
    compare_values("byte_merge_waited", 1, saw_miss);
  endtask

  // Head store waits on a fill while the rest pile up behind it
  task automatic test_buffer_full;
    logic [15:0] a;
    stall_seen = 1'b0;
    for (int i = 0; i < STB_ENTRIES + 2; i++) begin
      a = (i == 0) ? 16'h0234 : 16'h0100 + 16'(4 * ((i - 1) % 4));
      issue_store(a, brisc_pkg::W, 32'h4000_0000 + 32'(i));
    end
    compare_values("stall_raised", 1, stall_seen);
    for (int i = 0; i < STB_ENTRIES + 2; i++) begin
      a = (i == 0) ? 16'h0234 : 16'h0100 + 16'(4 * ((i - 1) % 4));
      load_and_compare("drained_store", a, brisc_pkg::W);
    end
  endtask

  task automatic test_dirty_evict;
    int unsigned writes_before;
    load_and_compare("evict_prefetch", 16'h0340, brisc_pkg::W);
    issue_store(16'h0344, brisc_pkg::W, 32'h0dd1_7e55);
    // Load that forwards gives the drain a free cycle
    load_and_compare("evict_forward", 16'h0344, brisc_pkg::W);
    grant_log.delete();
    writes_before = write_count;
    load_and_compare("evict_conflict", 16'h0540, brisc_pkg::W);
    compare_values("evict_request_count", 2, grant_log.size());
    if (grant_log.size() >= 2) begin
      compare_values("evict_write_first", 1, grant_log[0].write);
      compare_values("evict_write_addr", 16'h0340, grant_log[0].line_addr);
      compare_values("evict_write_line", expected_line(16'h0340), grant_log[0].data);
      compare_values("evict_read_second", 0, grant_log[1].write);
      compare_values("evict_read_addr", 16'h0540, grant_log[1].line_addr);
    end
    compare_values("evict_model_writes", writes_before + 1, write_count);
    load_and_compare("evict_refetch", 16'h0344, brisc_pkg::W);
  endtask

  // Four tags over indices 8 to 10
  task automatic test_random_mix;
    logic [31:0] r;
    logic [31:0] d;
    logic [7:0] tag;
    logic [3:0] index;
    logic [1:0] word_off;
    logic [1:0] byte_off;
    bit is_rd;
    brisc_pkg::data_size_e sz;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      draw_bits(stim_lfsr, 1, r);
      is_rd = r[0];
      draw_bits(stim_lfsr, 1, r);
      sz = (r[0] || !is_rd) ? brisc_pkg::W : brisc_pkg::B;
      draw_bits(stim_lfsr, 2, r);
      tag = 8'h10 + 8'(r);
      draw_bits(stim_lfsr, 2, r);
      index = 4'd8 + 4'(r % 3);
      draw_bits(stim_lfsr, 2, r);
      word_off = r[1:0];
      draw_bits(stim_lfsr, 2, r);
      byte_off = (sz == brisc_pkg::W) ? 2'd0 : r[1:0];
      if (is_rd) begin
        load_and_compare("random_load", {tag, index, word_off, byte_off}, sz);
      end else begin
        draw_bits(stim_lfsr, 32, d);
        issue_store({tag, index, word_off, byte_off}, brisc_pkg::W, d);
      end
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the DUT stopped completing accesses");
    finish_run(1'b1);
  end

  initial begin
    reset = 1'b1;
    enable = 1'b0;
    is_load = 1'b0;
    addr = '0;
    data_size = brisc_pkg::W;
    store_data = '0;
    for (int unsigned i = 0; i < (1 << 14); i++) begin
      ref_mem[i] = initial_word(i);
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_values("reset_stall_low", 0, stall);
    compare_values("reset_arbiter_req_low", 0, arbiter_req);
    test_cold_miss();
    test_load_sizes();
    test_forwarding();
    test_buffer_full();
    test_dirty_evict();
    test_random_mix();
    bus_idle(4);
    finish_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== project.f ====
logic/brisc_pkg.sv
logic/dcache_array.sv
logic/store_buffer.sv
logic/load_align.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := dcache_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
